/* src/rdma_pkg.sv */
package rdma_pkg;

    // field widths of the request channel.
    localparam int QPN_BITS = 24;
    localparam int LEN_BITS = 32;

    // reliable connection opcodes, 5-bit encoding.
    typedef enum logic [4:0] {
        RC_SEND_FIRST           = 5'h00,
        RC_SEND_MIDDLE          = 5'h01,
        RC_SEND_LAST            = 5'h02,
        RC_SEND                 = 5'h04,
        RC_RDMA_WRITE_FIRST     = 5'h06,
        RC_RDMA_WRITE_MIDDLE    = 5'h07,
        RC_RDMA_WRITE_LAST      = 5'h08,
        RC_RDMA_WRITE_ONLY      = 5'h0a,
        RC_RDMA_READ_REQUEST    = 5'h0c,
        RC_RDMA_READ_RESP_FIRST = 5'h0d,
        RC_RDMA_READ_RESP_MID   = 5'h0e,
        RC_RDMA_READ_RESP_LAST  = 5'h0f,
        RC_RDMA_READ_RESP_ONLY  = 5'h10,
        RC_ACK                  = 5'h11
    } rdma_opcode_t;

    // outstanding traffic class.
    // only a read request is counted as a read.
    typedef enum logic {
        CLASS_WR = 1'b0,
        CLASS_RD = 1'b1
    } ost_class_t;

endpackage

/* src/rdma_ost_tracker.sv */
`timescale 1ns/1ns

module rdma_ost_tracker #(
    parameter int N_OST          = 16,
    parameter int N_REGIONS_BITS = 2,
    parameter int PID_BITS       = 4
) (
    input  logic                      aclk,
    input  logic                      aresetn,

    input  logic                      req_fire,
    input  logic [N_REGIONS_BITS-1:0] req_vfid,
    input  logic [PID_BITS-1:0]       req_pid,

    input  logic                      ack_fire,
    input  logic [N_REGIONS_BITS-1:0] ack_vfid,
    input  logic [PID_BITS-1:0]       ack_pid,

    output logic                      room
);

    localparam int OST_BITS = $clog2(N_OST);
    localparam int Q_BITS   = N_REGIONS_BITS + PID_BITS;
    localparam int N_QUEUES = 1 << Q_BITS;

    // one queue per region and process pair.
    logic [OST_BITS-1:0] head [N_QUEUES];
    logic [OST_BITS-1:0] tail [N_QUEUES];
    logic [N_QUEUES-1:0] issued;

    logic [Q_BITS-1:0]   req_q;
    logic [Q_BITS-1:0]   ack_q;
    logic [OST_BITS-1:0] req_head_next;
    logic [OST_BITS-1:0] ack_tail_next;
    logic                ack_drains;

    assign req_q = {req_vfid, req_pid};
    assign ack_q = {ack_vfid, ack_pid};

    assign req_head_next = head[req_q] + 1'b1;
    assign ack_tail_next = tail[ack_q] + 1'b1;

    // last outstanding request of the queue retires.
    assign ack_drains = (ack_tail_next == head[ack_q]);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < N_QUEUES; i++) begin
                head[i] <= '0;
                tail[i] <= '0;
            end
            issued <= '0;
        end else begin
            if (ack_fire) begin
                tail[ack_q] <= ack_tail_next;
                if (ack_drains) begin
                    issued[ack_q] <= 1'b0;
                end
            end
            // a request to the same queue keeps it issued.
            if (req_fire) begin
                head[req_q]   <= req_head_next;
                issued[req_q] <= 1'b1;
            end
        end
    end

    // full once head has wrapped onto tail with requests issued.
    assign room = !issued[req_q] || (head[req_q] != tail[req_q]);

    // acks only for queues with something outstanding.
    ack_on_issued_queue: assert property (
        @(posedge aclk) disable iff (!aresetn)
        ack_fire |-> issued[ack_q]
    ) else $error("ack to queue %0d with nothing issued", ack_q);

endmodule

/* src/rdma_flow_ctrl.sv */
`timescale 1ns/1ns

module rdma_flow_ctrl #(
    parameter int N_REGIONS_BITS = 2,
    parameter int PID_BITS       = 4
) (
    input  logic                           aclk,
    input  logic                           aresetn,

    input  logic                           s_req_valid,
    output logic                           s_req_ready,
    input  rdma_pkg::rdma_opcode_t         s_req_opcode,
    input  logic [rdma_pkg::QPN_BITS-1:0]  s_req_qpn,
    input  logic [rdma_pkg::LEN_BITS-1:0]  s_req_len,

    output logic                           m_req_valid,
    input  logic                           m_req_ready,
    output rdma_pkg::rdma_opcode_t         m_req_opcode,
    output logic [rdma_pkg::QPN_BITS-1:0]  m_req_qpn,
    output logic [rdma_pkg::LEN_BITS-1:0]  m_req_len,

    input  logic                           s_ack_valid,
    output logic                           s_ack_ready,
    input  logic                           s_ack_rd,
    input  logic [N_REGIONS_BITS-1:0]      s_ack_vfid,
    input  logic [PID_BITS-1:0]            s_ack_pid,

    input  logic                           rd_room,
    output logic                           rd_req_fire,
    output logic                           rd_ack_fire,

    input  logic                           wr_room,
    output logic                           wr_req_fire,
    output logic                           wr_ack_fire,

    output logic [N_REGIONS_BITS-1:0]      req_vfid,
    output logic [PID_BITS-1:0]            req_pid,
    output logic [N_REGIONS_BITS-1:0]      ack_vfid,
    output logic [PID_BITS-1:0]            ack_pid
);

    rdma_pkg::ost_class_t req_class;
    rdma_pkg::ost_class_t ack_class;
    logic                 class_room;
    logic                 req_fire;
    logic                 ack_fire;

    // qpn low bits give the pid, next bits the region.
    assign req_pid  = s_req_qpn[0 +: PID_BITS];
    assign req_vfid = s_req_qpn[PID_BITS +: N_REGIONS_BITS];

    assign ack_pid  = s_ack_pid;
    assign ack_vfid = s_ack_vfid;

    assign req_class = (s_req_opcode == rdma_pkg::RC_RDMA_READ_REQUEST) ?
                       rdma_pkg::CLASS_RD : rdma_pkg::CLASS_WR;
    assign ack_class = s_ack_rd ? rdma_pkg::CLASS_RD : rdma_pkg::CLASS_WR;

    assign class_room = (req_class == rdma_pkg::CLASS_RD) ? rd_room : wr_room;

    // acks always win; a request waits for a free cycle.
    assign ack_fire = s_ack_valid;
    assign req_fire = s_req_valid && !s_ack_valid && m_req_ready && class_room;

    assign s_ack_ready = ack_fire;
    assign s_req_ready = req_fire;

    assign rd_req_fire = req_fire && (req_class == rdma_pkg::CLASS_RD);
    assign wr_req_fire = req_fire && (req_class == rdma_pkg::CLASS_WR);
    assign rd_ack_fire = ack_fire && (ack_class == rdma_pkg::CLASS_RD);
    assign wr_ack_fire = ack_fire && (ack_class == rdma_pkg::CLASS_WR);

    // zero-latency forward.
    assign m_req_valid  = req_fire;
    assign m_req_opcode = s_req_opcode;
    assign m_req_qpn    = s_req_qpn;
    assign m_req_len    = s_req_len;

    no_spurious_forward: assert property (
        @(posedge aclk) disable iff (!aresetn)
        $rose(m_req_valid) |-> s_req_valid && m_req_ready
    ) else $error("m_req_valid rose without an upstream request");

    // at most one tracker update per cycle.
    req_ack_exclusive: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !((rd_req_fire || wr_req_fire) && (rd_ack_fire || wr_ack_fire))
    ) else $error("request and ack fired in the same cycle");

endmodule

/* src/rdma_flow_top.sv */
`timescale 1ns/1ns

module rdma_flow_top #(
    parameter int N_OST          = 16,
    parameter int N_REGIONS_BITS = 2,
    parameter int PID_BITS       = 4
) (
    input  logic                           aclk,
    input  logic                           aresetn,

    input  logic                           s_req_valid,
    output logic                           s_req_ready,
    input  rdma_pkg::rdma_opcode_t         s_req_opcode,
    input  logic [rdma_pkg::QPN_BITS-1:0]  s_req_qpn,
    input  logic [rdma_pkg::LEN_BITS-1:0]  s_req_len,

    output logic                           m_req_valid,
    input  logic                           m_req_ready,
    output rdma_pkg::rdma_opcode_t         m_req_opcode,
    output logic [rdma_pkg::QPN_BITS-1:0]  m_req_qpn,
    output logic [rdma_pkg::LEN_BITS-1:0]  m_req_len,

    input  logic                           s_ack_valid,
    output logic                           s_ack_ready,
    input  logic                           s_ack_rd,
    input  logic [N_REGIONS_BITS-1:0]      s_ack_vfid,
    input  logic [PID_BITS-1:0]            s_ack_pid
);

    logic                      rd_room;
    logic                      rd_req_fire;
    logic                      rd_ack_fire;
    logic                      wr_room;
    logic                      wr_req_fire;
    logic                      wr_ack_fire;
    logic [N_REGIONS_BITS-1:0] req_vfid;
    logic [PID_BITS-1:0]       req_pid;
    logic [N_REGIONS_BITS-1:0] ack_vfid;
    logic [PID_BITS-1:0]       ack_pid;

    rdma_flow_ctrl #(
        .N_REGIONS_BITS (N_REGIONS_BITS),
        .PID_BITS       (PID_BITS)
    ) ctrl (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .s_req_valid  (s_req_valid),
        .s_req_ready  (s_req_ready),
        .s_req_opcode (s_req_opcode),
        .s_req_qpn    (s_req_qpn),
        .s_req_len    (s_req_len),
        .m_req_valid  (m_req_valid),
        .m_req_ready  (m_req_ready),
        .m_req_opcode (m_req_opcode),
        .m_req_qpn    (m_req_qpn),
        .m_req_len    (m_req_len),
        .s_ack_valid  (s_ack_valid),
        .s_ack_ready  (s_ack_ready),
        .s_ack_rd     (s_ack_rd),
        .s_ack_vfid   (s_ack_vfid),
        .s_ack_pid    (s_ack_pid),
        .rd_room      (rd_room),
        .rd_req_fire  (rd_req_fire),
        .rd_ack_fire  (rd_ack_fire),
        .wr_room      (wr_room),
        .wr_req_fire  (wr_req_fire),
        .wr_ack_fire  (wr_ack_fire),
        .req_vfid     (req_vfid),
        .req_pid      (req_pid),
        .ack_vfid     (ack_vfid),
        .ack_pid      (ack_pid)
    );

    // read class.
    rdma_ost_tracker #(
        .N_OST          (N_OST),
        .N_REGIONS_BITS (N_REGIONS_BITS),
        .PID_BITS       (PID_BITS)
    ) rd_tracker (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .req_fire (rd_req_fire),
        .req_vfid (req_vfid),
        .req_pid  (req_pid),
        .ack_fire (rd_ack_fire),
        .ack_vfid (ack_vfid),
        .ack_pid  (ack_pid),
        .room     (rd_room)
    );

    // write class, everything that is not a read request.
    rdma_ost_tracker #(
        .N_OST          (N_OST),
        .N_REGIONS_BITS (N_REGIONS_BITS),
        .PID_BITS       (PID_BITS)
    ) wr_tracker (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .req_fire (wr_req_fire),
        .req_vfid (req_vfid),
        .req_pid  (req_pid),
        .ack_fire (wr_ack_fire),
        .ack_vfid (ack_vfid),
        .ack_pid  (ack_pid),
        .room     (wr_room)
    );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    input  logic rst_req,
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // reset at start, then again on every rst_req.
    initial begin
        aresetn = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(posedge aclk);
            aresetn <= 1'b1;
            do @(posedge aclk); while (!rst_req);
            aresetn <= 1'b0;
        end
    end

endmodule

/* tb/tb_rdma_flow.sv */
`timescale 1ns/1ns

module tb_rdma_flow;

    localparam int N_OST       = 4;
    localparam int NRB         = 1;
    localparam int PIDB        = 2;
    localparam int QB          = NRB + PIDB;
    localparam int NQ          = 1 << QB;
    localparam int QPN_W       = rdma_pkg::QPN_BITS;
    localparam int LEN_W       = rdma_pkg::LEN_BITS;
    localparam int CLK_PERIOD  = 8;
    localparam int RAND_CYCLES = 2000;
    localparam int TEST_CYCLES = RAND_CYCLES + 400;
    localparam int MARGIN      = 500;
    localparam int WATCHDOG_NS = (TEST_CYCLES + MARGIN) * CLK_PERIOD;

    localparam logic [31:0]      SEED  = 32'h13ee;
    localparam logic [QPN_W-1:0] QPN_A = 24'h3ca005;
    localparam logic [QPN_W-1:0] QPN_B = 24'h123402;
    localparam logic [QB-1:0]    Q_A   = QPN_A[QB-1:0];

    logic                   aclk;
    logic                   aresetn;
    logic                   rst_req;

    logic                   s_req_valid;
    logic                   s_req_ready;
    rdma_pkg::rdma_opcode_t s_req_opcode;
    logic [QPN_W-1:0]       s_req_qpn;
    logic [LEN_W-1:0]       s_req_len;
    logic                   m_req_valid;
    logic                   m_req_ready;
    rdma_pkg::rdma_opcode_t m_req_opcode;
    logic [QPN_W-1:0]       m_req_qpn;
    logic [LEN_W-1:0]       m_req_len;
    logic                   s_ack_valid;
    logic                   s_ack_ready;
    logic                   s_ack_rd;
    logic [NRB-1:0]         s_ack_vfid;
    logic [PIDB-1:0]        s_ack_pid;

    // outstanding requests per class and queue, from observed fires.
    int                     rd_cnt [NQ];
    int                     wr_cnt [NQ];
    int                     req_cnt;
    int                     total_cnt;
    logic [QB-1:0]          req_q;
    logic [QB-1:0]          ack_q;

    int                     errors;
    int                     limit_hits;
    int                     prio_hits;

    tb_clk_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (5)
    ) clk_gen (
        .rst_req (rst_req),
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    rdma_flow_top #(
        .N_OST          (N_OST),
        .N_REGIONS_BITS (NRB),
        .PID_BITS       (PIDB)
    ) rdma_flow_top_inst (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .s_req_valid  (s_req_valid),
        .s_req_ready  (s_req_ready),
        .s_req_opcode (s_req_opcode),
        .s_req_qpn    (s_req_qpn),
        .s_req_len    (s_req_len),
        .m_req_valid  (m_req_valid),
        .m_req_ready  (m_req_ready),
        .m_req_opcode (m_req_opcode),
        .m_req_qpn    (m_req_qpn),
        .m_req_len    (m_req_len),
        .s_ack_valid  (s_ack_valid),
        .s_ack_ready  (s_ack_ready),
        .s_ack_rd     (s_ack_rd),
        .s_ack_vfid   (s_ack_vfid),
        .s_ack_pid    (s_ack_pid)
    );

    // region above pid, both taken from the low qpn bits.
    assign req_q = {s_req_qpn[PIDB +: NRB], s_req_qpn[0 +: PIDB]};
    assign ack_q = {s_ack_vfid, s_ack_pid};

    assign req_cnt = (s_req_opcode == rdma_pkg::RC_RDMA_READ_REQUEST) ?
                     rd_cnt[req_q] : wr_cnt[req_q];

    always_comb begin
        total_cnt = 0;
        for (int i = 0; i < NQ; i++) begin
            total_cnt = total_cnt + rd_cnt[i] + wr_cnt[i];
        end
    end

    // requests count when the source side hands them over.
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < NQ; i++) begin
                rd_cnt[i] <= 0;
                wr_cnt[i] <= 0;
            end
        end else begin
            if (s_req_valid && s_req_ready) begin
                if (s_req_opcode == rdma_pkg::RC_RDMA_READ_REQUEST) begin
                    rd_cnt[req_q] <= rd_cnt[req_q] + 1;
                end else begin
                    wr_cnt[req_q] <= wr_cnt[req_q] + 1;
                end
            end
            if (s_ack_valid && s_ack_ready) begin
                if (s_ack_rd) begin
                    rd_cnt[ack_q] <= rd_cnt[ack_q] - 1;
                end else begin
                    wr_cnt[ack_q] <= wr_cnt[ack_q] - 1;
                end
            end
        end
    end

    // reach counters for the report.
    always @(posedge aclk) begin
        if (aresetn && s_req_valid && req_cnt >= N_OST) begin
            limit_hits++;
        end
        if (aresetn && s_req_valid && s_ack_valid) begin
            prio_hits++;
        end
    end

    passthrough: assert property (
        @(posedge aclk) disable iff (!aresetn)
        m_req_valid |-> s_req_valid && m_req_ready && !s_ack_valid
            && m_req_opcode == s_req_opcode && m_req_qpn == s_req_qpn
            && m_req_len == s_req_len
    ) else begin
        errors++;
        $display("error %0t: m_req does not carry an accepted s_req", $time);
    end

    fire_matches: assert property (
        @(posedge aclk) disable iff (!aresetn)
        s_req_ready == m_req_valid
    ) else begin
        errors++;
        $display("error %0t: s_req_ready and m_req_valid differ", $time);
    end

    limit_refused: assert property (
        @(posedge aclk) disable iff (!aresetn)
        s_req_valid && req_cnt >= N_OST |-> !s_req_ready
    ) else begin
        errors++;
        $display("error %0t: request accepted on full queue %0d", $time, req_q);
    end

    below_limit_taken: assert property (
        @(posedge aclk) disable iff (!aresetn)
        s_req_valid && req_cnt < N_OST && m_req_ready && !s_ack_valid |-> s_req_ready
    ) else begin
        errors++;
        $display("error %0t: request refused on queue %0d with room", $time, req_q);
    end

    ack_ready_follows: assert property (
        @(posedge aclk)
        s_ack_ready == s_ack_valid
    ) else begin
        errors++;
        $display("error %0t: s_ack_ready differs from s_ack_valid", $time);
    end

    ack_blocks_req: assert property (
        @(posedge aclk)
        s_ack_valid |-> !s_req_ready
    ) else begin
        errors++;
        $display("error %0t: request accepted next to an ack", $time);
    end

    backpressure_stall: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !m_req_ready |-> !s_req_ready && !m_req_valid
    ) else begin
        errors++;
        $display("error %0t: request passed while m_req_ready low", $time);
    end

    backpressure_counts: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !m_req_ready && !s_ack_valid |=> total_cnt == $past(total_cnt)
    ) else begin
        errors++;
        $display("error %0t: counts moved under back-pressure", $time);
    end

    // holds in reset and the cycle after too.
    idle_outputs_low: assert property (
        @(posedge aclk)
        !s_req_valid && !s_ack_valid |-> !m_req_valid && !s_req_ready && !s_ack_ready
    ) else begin
        errors++;
        $display("error %0t: outputs active with idle inputs", $time);
    end

    function automatic rdma_pkg::rdma_opcode_t pick_opcode(input logic [1:0] sel);
        case (sel)
            2'd0:    return rdma_pkg::RC_RDMA_READ_REQUEST;
            2'd1:    return rdma_pkg::RC_SEND;
            2'd2:    return rdma_pkg::RC_RDMA_WRITE_ONLY;
            default: return rdma_pkg::RC_RDMA_WRITE_FIRST;
        endcase
    endfunction

    // high qpn bits are don't care.
    function automatic logic [QPN_W-1:0] qpn_for(input logic [QB-1:0] q);
        logic [QPN_W-1:0] qpn;
        qpn = 24'h5a6b78;
        qpn[QB-1:0] = q;
        return qpn;
    endfunction

    task automatic idle_inputs();
        s_req_valid  <= 1'b0;
        s_req_opcode <= rdma_pkg::RC_SEND;
        s_req_qpn    <= '0;
        s_req_len    <= '0;
        m_req_ready  <= 1'b1;
        s_ack_valid  <= 1'b0;
        s_ack_rd     <= 1'b0;
        s_ack_vfid   <= '0;
        s_ack_pid    <= '0;
    endtask

    // hold one request until taken or max_cycles pass.
    task automatic offer_req(input rdma_pkg::rdma_opcode_t op,
                             input logic [QPN_W-1:0] qpn, input int max_cycles);
        int   n;
        logic taken;
        n = 0;
        taken = 1'b0;
        s_req_valid  <= 1'b1;
        s_req_opcode <= op;
        s_req_qpn    <= qpn;
        s_req_len    <= $urandom();
        while (!taken && n < max_cycles) begin
            @(negedge aclk);
            taken = s_req_ready;
            @(posedge aclk);
            // an ack only stays for one cycle.
            s_ack_valid <= 1'b0;
            n++;
        end
        s_req_valid <= 1'b0;
    endtask

    task automatic send_ack(input logic rd, input logic [QB-1:0] q);
        int   n;
        logic taken;
        n = 0;
        taken = 1'b0;
        s_ack_valid <= 1'b1;
        s_ack_rd    <= rd;
        s_ack_vfid  <= q[QB-1 -: NRB];
        s_ack_pid   <= q[PIDB-1:0];
        while (!taken && n < 4) begin
            @(negedge aclk);
            taken = s_ack_ready;
            @(posedge aclk);
            n++;
        end
        s_ack_valid <= 1'b0;
    endtask

    task automatic fill_queue(input rdma_pkg::rdma_opcode_t op, input logic [QPN_W-1:0] qpn);
        repeat (N_OST) offer_req(op, qpn, 4);
    endtask

    task automatic wait_reset_release();
        do @(posedge aclk); while (!aresetn);
        @(posedge aclk);
    endtask

    task automatic apply_reset();
        rst_req <= 1'b1;
        @(posedge aclk);
        rst_req <= 1'b0;
        do @(posedge aclk); while (aresetn);
        wait_reset_release();
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0]   rnd;
        logic [QB-1:0] ack_q_n;
        logic          ack_rd_n;
        logic          ack_v_n;
        int            avail;
        for (int c = 0; c < cycles; c++) begin
            @(negedge aclk);
            rnd = $urandom();
            ack_q_n = rnd[QB-1:0];
            ack_rd_n = rnd[8];
            avail = ack_rd_n ? rd_cnt[ack_q_n] : wr_cnt[ack_q_n];
            // the ack on the bus now retires at the next edge.
            if (s_ack_valid && s_ack_rd == ack_rd_n && ack_q == ack_q_n) begin
                avail = avail - 1;
            end
            ack_v_n = (rnd[15:9] < 7'd30) && (avail > 0);
            @(posedge aclk);
            s_ack_valid <= ack_v_n;
            s_ack_rd    <= ack_rd_n;
            s_ack_vfid  <= ack_q_n[QB-1 -: NRB];
            s_ack_pid   <= ack_q_n[PIDB-1:0];
            rnd = $urandom();
            s_req_valid  <= (rnd[6:0] < 7'd80);
            s_req_opcode <= pick_opcode(rnd[8:7]);
            m_req_ready  <= (rnd[15:9] < 7'd100);
            s_req_len    <= $urandom();
            rnd = $urandom();
            s_req_qpn    <= rnd[QPN_W-1:0];
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        errors = 0;
        limit_hits = 0;
        prio_hits = 0;
        rst_req <= 1'b0;
        idle_inputs();
        void'($urandom(SEED));
        wait_reset_release();

        // read class full on queue a, writes still pass.
        fill_queue(rdma_pkg::RC_RDMA_READ_REQUEST, QPN_A);
        offer_req(rdma_pkg::RC_RDMA_READ_REQUEST, QPN_A, 3);
        offer_req(rdma_pkg::RC_SEND, QPN_A, 4);
        fill_queue(rdma_pkg::RC_RDMA_WRITE_ONLY, QPN_B);
        offer_req(rdma_pkg::RC_RDMA_WRITE_FIRST, QPN_B, 3);
        offer_req(rdma_pkg::RC_RDMA_READ_REQUEST, QPN_B, 4);

        // stalled sink, then one ack frees one slot.
        m_req_ready <= 1'b0;
        offer_req(rdma_pkg::RC_SEND, QPN_A, 4);
        m_req_ready <= 1'b1;
        send_ack(1'b1, Q_A);
        offer_req(rdma_pkg::RC_RDMA_READ_REQUEST, QPN_A, 4);
        offer_req(rdma_pkg::RC_RDMA_READ_REQUEST, QPN_A, 3);

        // request collides with an ack and waits.
        s_ack_valid <= 1'b1;
        s_ack_rd    <= 1'b1;
        s_ack_vfid  <= Q_A[QB-1 -: NRB];
        s_ack_pid   <= Q_A[PIDB-1:0];
        offer_req(rdma_pkg::RC_RDMA_READ_REQUEST, QPN_B, 4);

        random_traffic(RAND_CYCLES);
        idle_inputs();
        apply_reset();

        for (int q = 0; q < NQ; q++) begin
            fill_queue(rdma_pkg::RC_RDMA_READ_REQUEST, qpn_for(q[QB-1:0]));
            fill_queue(rdma_pkg::RC_RDMA_WRITE_FIRST, qpn_for(q[QB-1:0]));
        end
        offer_req(rdma_pkg::RC_SEND, qpn_for(Q_A), 3);
        idle_inputs();
        repeat (2) @(posedge aclk);

        if (limit_hits == 0) begin
            errors++;
            $display("the stimulus never offered a request to a full queue");
        end
        if (prio_hits == 0) begin
            errors++;
            $display("the stimulus never sent a request next to an ack");
        end
        $display("closing report: %0d errors, %0d limit hits, %0d ack collisions",
                 errors, limit_hits, prio_hits);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
src/rdma_pkg.sv
src/rdma_ost_tracker.sv
src/rdma_flow_ctrl.sv
src/rdma_flow_top.sv
tb/tb_clk_gen.sv
tb/tb_rdma_flow.sv

/* run.sh */
#!/bin/sh
# build and run the flow regulator testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -f src.f \
    --top-module tb_rdma_flow -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^>>> PASS$" sim.log && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
